/* Bender.yml */
package:
  name: board_top

sources:
  - logic/board_pkg.sv
  - logic/display_pkg.sv
  - logic/key_conditioner.sv
  - logic/lab_counter.sv
  - logic/tm1638_serial_tx.sv
  - logic/board_top.sv
  - target: test
    files:
      - verif/tb_board_top.sv

/* board_top.f */
logic/board_pkg.sv
logic/display_pkg.sv
logic/key_conditioner.sv
logic/lab_counter.sv
logic/tm1638_serial_tx.sv
logic/board_top.sv
verif/tb_board_top.sv

/* logic/board_pkg.sv */
package board_pkg;

    //------------------------------------------------
    // Board buttons
    //------------------------------------------------

    // Active-low push buttons on the board
    localparam int w_key = 2;

    // Reverse the button order so that key 0 sits on the other pin
    localparam bit reverse_keys = 1'b1;

    //------------------------------------------------
    // Debounce timing
    //------------------------------------------------

    // Cycles a synchronized level must hold before it is accepted.
    // Kept short here, a real board would use milliseconds
    localparam int debounce_cycles = 16;

    // Stability counter width, wide enough for the full count
    localparam int w_debounce = $clog2(debounce_cycles + 1);

endpackage

/* logic/board_top.sv */
`timescale 1ns/1ps

module board_top (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic [board_pkg::w_key-1:0] i_key,     // Board buttons, active low
    output logic                        o_tm_stb,
    output logic                        o_tm_clk,
    output logic                        o_tm_dio
);

    import board_pkg::*;
    import display_pkg::*;

    logic [w_key-1:0]        press;
    logic                    word_valid;
    logic                    word_is_led;
    logic [w_word_index-1:0] word_index;
    logic [w_word_data-1:0]  word_data;
    logic                    credit;

    //------------------------------------------------
    // Buttons to counter to TM1638 pins
    //------------------------------------------------

    key_conditioner u_key_conditioner (
        .clk           ( clk          ),
        .i_reset       ( i_reset      ),
        .i_key         ( i_key        ),
        .o_press       ( press        )
    );

    lab_counter u_lab_counter (
        .clk           ( clk          ),
        .i_reset       ( i_reset      ),
        .i_press       ( press        ),
        .i_credit      ( credit       ),
        .o_word_valid  ( word_valid   ),
        .o_word_is_led ( word_is_led  ),
        .o_word_index  ( word_index   ),
        .o_word_data   ( word_data    )
    );

    tm1638_serial_tx u_tm1638_serial_tx (
        .clk           ( clk          ),
        .i_reset       ( i_reset      ),
        .i_word_valid  ( word_valid   ),
        .i_word_is_led ( word_is_led  ),
        .i_word_index  ( word_index   ),
        .i_word_data   ( word_data    ),
        .o_credit      ( credit       ),
        .o_tm_stb      ( o_tm_stb     ),
        .o_tm_clk      ( o_tm_clk     ),
        .o_tm_dio      ( o_tm_dio     )
    );

endmodule

/* logic/display_pkg.sv */
package display_pkg;

    //------------------------------------------------
    // Display word fields
    //------------------------------------------------

    localparam int w_tm_digit   = 8;  // Seven-segment positions
    localparam int w_word_index = 3;  // Position inside a half frame
    localparam int w_word_data  = 8;  // Segment byte or LED byte

    //------------------------------------------------
    // Transmit buffer and credits
    //------------------------------------------------

    localparam int tx_depth  = 4;                     // Words in flight
    localparam int w_credit  = $clog2(tx_depth + 1);  // Holds 0 .. tx_depth
    localparam int w_tx_ptr  = $clog2(tx_depth);

    //------------------------------------------------
    // Serial timing and TM1638 commands
    //------------------------------------------------

    localparam int sio_half_cycles = 2;  // Clocks per serial half period
    localparam int w_sio_div       = $clog2(sio_half_cycles + 1);

    // Fixed address mode, even addresses hold digits, odd ones LEDs
    localparam logic [7:0] cmd_seg_base = 8'hC0;
    localparam logic [7:0] cmd_led_base = 8'hC1;

    // Bit 0 is segment a up to bit 6 for g, decimal point stays dark
    function automatic logic [7:0] hex_to_segments(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'h3F;
            4'h1: return 8'h06;
            4'h2: return 8'h5B;
            4'h3: return 8'h4F;
            4'h4: return 8'h66;
            4'h5: return 8'h6D;
            4'h6: return 8'h7D;
            4'h7: return 8'h07;
            4'h8: return 8'h7F;
            4'h9: return 8'h6F;
            4'hA: return 8'h77;
            4'hB: return 8'h7C;
            4'hC: return 8'h39;
            4'hD: return 8'h5E;
            4'hE: return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

endpackage

/* logic/key_conditioner.sv */
`timescale 1ns/1ps

module key_conditioner (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic [board_pkg::w_key-1:0] i_key,    // Active low
    output logic [board_pkg::w_key-1:0] o_press
);

    import board_pkg::*;

    logic [w_key-1:0]      key_ordered;
    logic [w_key-1:0]      key_active;
    logic [w_key-1:0]      sync_q1;
    logic [w_key-1:0]      sync_q2;
    logic [w_key-1:0]      level;                // Debounced, 1 = pressed
    logic [w_key-1:0]      level_d;
    logic [w_debounce-1:0] stable_cnt [w_key];

    //------------------------------------------------
    // Order, polarity and synchronizer
    //------------------------------------------------

    always_comb begin
        for (int k = 0; k < w_key; k++) begin
            key_ordered[k] = reverse_keys ? i_key[w_key - 1 - k] : i_key[k];
        end
    end

    assign key_active = ~key_ordered;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= key_active;
            sync_q2 <= sync_q1;
        end
    end

    //------------------------------------------------
    // Debounce
    //------------------------------------------------

    // A differing level must persist for debounce_cycles before it is taken
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int k = 0; k < w_key; k++) begin
                stable_cnt[k] <= '0;
            end
            level   <= '0;
            level_d <= '0;
        end else begin
            level_d <= level;
            for (int k = 0; k < w_key; k++) begin
                if (sync_q2[k] == level[k]) begin
                    stable_cnt[k] <= '0;              // Bounce restarts the wait
                end else if (stable_cnt[k] == w_debounce'(debounce_cycles - 1)) begin
                    level[k]      <= sync_q2[k];
                    stable_cnt[k] <= '0;
                end else begin
                    stable_cnt[k] <= stable_cnt[k] + 1'b1;
                end
            end
        end
    end

    assign o_press = level & ~level_d;               // Rising edge only

    // A press needs the synchronized key held for the whole debounce window
    a_press_debounced: assert property (@(posedge clk) disable iff (i_reset)
        (o_press & ~$past(sync_q2, debounce_cycles)) == '0)
        else $error("key_conditioner: press without a stable key");

endmodule

/* logic/lab_counter.sv */
`timescale 1ns/1ps

module lab_counter (
    input  logic                                 clk,
    input  logic                                 i_reset,
    input  logic [board_pkg::w_key-1:0]          i_press,
    input  logic                                 i_credit,
    output logic                                 o_word_valid,
    output logic                                 o_word_is_led,
    output logic [display_pkg::w_word_index-1:0] o_word_index,
    output logic [display_pkg::w_word_data-1:0]  o_word_data
);

    import display_pkg::*;

    localparam int w_value     = 32;
    localparam int w_frame_pos = w_word_index + 1;  // Top bit selects the LED half
    localparam int last_digit  = w_tm_digit - 1;

    logic [w_value-1:0]      counter;
    logic [w_value-1:0]      last_sent;
    logic [w_value-1:0]      frame_value;    // Snapshot held for the whole frame
    logic [w_frame_pos-1:0]  frame_pos;
    logic                    frame_busy;
    logic                    first_frame;
    logic [w_credit-1:0]     credits;
    logic [w_word_index-1:0] nibble_sel;
    logic                    frame_start;

    //------------------------------------------------
    // Counter
    //------------------------------------------------

    always_ff @(posedge clk) begin
        if (i_reset) begin
            counter <= '0;
        end else if (i_press[1]) begin
            counter <= '0;                          // Clear wins over increment
        end else if (i_press[0]) begin
            counter <= counter + 1'b1;
        end
    end

    //------------------------------------------------
    // Frame engine
    //------------------------------------------------

    assign frame_start = !frame_busy && (first_frame || counter != last_sent);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            frame_busy  <= 1'b0;
            first_frame <= 1'b1;                    // Show zero once after reset
            frame_pos   <= '0;
            last_sent   <= '0;
        end else if (frame_start) begin
            frame_busy  <= 1'b1;
            first_frame <= 1'b0;
            frame_pos   <= '0;
            last_sent   <= counter;
        end else if (o_word_valid) begin
            frame_pos <= frame_pos + 1'b1;
            if (frame_pos == '1) begin
                frame_busy <= 1'b0;                 // Last LED word sent
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_start) begin
            frame_value <= counter;
        end
    end

    //------------------------------------------------
    // Credits
    //------------------------------------------------

    // One credit spent per word, one returned per word sent on the wire
    always_ff @(posedge clk) begin
        if (i_reset) begin
            credits <= w_credit'(tx_depth);
        end else begin
            credits <= credits - w_credit'(o_word_valid) + w_credit'(i_credit);
        end
    end

    //------------------------------------------------
    // Word output
    //------------------------------------------------

    assign o_word_valid  = frame_busy && (credits != '0);
    assign o_word_is_led = frame_pos[w_frame_pos-1];
    assign o_word_index  = frame_pos[w_word_index-1:0];

    // Digit 0 carries the top nibble
    assign nibble_sel = w_word_index'(last_digit) - o_word_index;

    always_comb begin
        if (o_word_is_led) begin
            o_word_data = w_word_data'(frame_value[o_word_index]);
        end else begin
            o_word_data = hex_to_segments(frame_value[{nibble_sel, 2'b00} +: 4]);
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (i_reset)
        credits <= w_credit'(tx_depth))
        else $error("lab_counter: more credits returned than issued");

endmodule

/* logic/tm1638_serial_tx.sv */
`timescale 1ns/1ps

module tm1638_serial_tx (
    input  logic                                 clk,
    input  logic                                 i_reset,
    input  logic                                 i_word_valid,
    input  logic                                 i_word_is_led,
    input  logic [display_pkg::w_word_index-1:0] i_word_index,
    input  logic [display_pkg::w_word_data-1:0]  i_word_data,
    output logic                                 o_credit,
    output logic                                 o_tm_stb,
    output logic                                 o_tm_clk,
    output logic                                 o_tm_dio
);

    import display_pkg::*;

    localparam int w_frame_bits = 16;  // Address byte then data byte
    localparam int w_bit_cnt    = $clog2(w_frame_bits);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,   // Strobe low, clock still high
        ST_LOW,
        ST_HIGH,
        ST_STOP,    // Last clock high, strobe about to rise
        ST_GAP
    } tx_state_t;

    tx_state_t state;

    logic                    buf_is_led [tx_depth];
    logic [w_word_index-1:0] buf_index  [tx_depth];
    logic [w_word_data-1:0]  buf_data   [tx_depth];
    logic [w_tx_ptr-1:0]     wr_ptr;
    logic [w_tx_ptr-1:0]     rd_ptr;
    logic [w_credit-1:0]     fill;
    logic                    pop;
    logic [7:0]              addr_byte;
    logic [w_frame_bits-1:0] shift_reg;
    logic [w_bit_cnt-1:0]    bit_cnt;
    logic [w_sio_div-1:0]    div_cnt;
    logic                    half_done;

    //------------------------------------------------
    // Word buffer
    //------------------------------------------------

    assign pop = (state == ST_IDLE) && (fill != '0);

    always_ff @(posedge clk) begin
        if (i_word_valid) begin
            buf_is_led[wr_ptr] <= i_word_is_led;
            buf_index[wr_ptr]  <= i_word_index;
            buf_data[wr_ptr]   <= i_word_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (i_word_valid) begin
                wr_ptr <= (wr_ptr == w_tx_ptr'(tx_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == w_tx_ptr'(tx_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill <= fill + w_credit'(i_word_valid) - w_credit'(pop);
        end
    end

    assign addr_byte = (buf_is_led[rd_ptr] ? cmd_led_base : cmd_seg_base)
                     + 8'({buf_index[rd_ptr], 1'b0});

    //------------------------------------------------
    // Serial engine
    //------------------------------------------------

    assign half_done = (div_cnt == w_sio_div'(sio_half_cycles - 1));

    always_ff @(posedge clk) begin
        if (i_reset || state == ST_IDLE || half_done) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shift_reg <= {buf_data[rd_ptr], addr_byte};  // LSB of address goes first
        end else if (state == ST_HIGH && half_done) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state    <= ST_IDLE;
            bit_cnt  <= '0;
            o_tm_stb <= 1'b1;
            o_tm_clk <= 1'b1;
            o_tm_dio <= 1'b0;
            o_credit <= 1'b0;
        end else begin
            o_credit <= 1'b0;
            case (state)
                ST_IDLE: if (pop) begin
                    o_tm_stb <= 1'b0;
                    bit_cnt  <= '0;
                    state    <= ST_START;
                end
                ST_START: if (half_done) begin
                    o_tm_clk <= 1'b0;
                    o_tm_dio <= shift_reg[0];
                    state    <= ST_LOW;
                end
                ST_LOW: if (half_done) begin
                    o_tm_clk <= 1'b1;                    // Reader samples here
                    state    <= ST_HIGH;
                end
                ST_HIGH: if (half_done) begin
                    if (bit_cnt == w_bit_cnt'(w_frame_bits - 1)) begin
                        state <= ST_STOP;
                    end else begin
                        bit_cnt  <= bit_cnt + 1'b1;
                        o_tm_clk <= 1'b0;
                        o_tm_dio <= shift_reg[1];        // Next bit before shift lands
                        state    <= ST_LOW;
                    end
                end
                ST_STOP: if (half_done) begin
                    o_tm_stb <= 1'b1;
                    o_tm_dio <= 1'b0;
                    o_credit <= 1'b1;                    // Buffer slot free for good
                    state    <= ST_GAP;
                end
                default: if (half_done) begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (i_reset)
        i_word_valid |-> fill != w_credit'(tx_depth))
        else $error("tm1638_serial_tx: word pushed into full buffer");

    a_clk_idle_high: assert property (@(posedge clk) disable iff (i_reset)
        o_tm_stb |-> o_tm_clk)
        else $error("tm1638_serial_tx: serial clock low outside strobe window");

endmodule

/* verif/tb_board_top.sv */
`timescale 1ns/1ps

module tb_board_top;

    import board_pkg::*;
    import display_pkg::*;

    localparam int clk_period      = 20;
    localparam int word_cycles     = (2 * 16 + 4) * sio_half_cycles + 1;
    localparam int frame_cycles    = 16 * word_cycles;
    localparam int settle_cycles   = 2 * debounce_cycles + 8;  // Sync plus debounce, with margin
    localparam int budget_frames   = 28;
    localparam int budget_presses  = 28;
    localparam int watchdog_cycles =
        2 * (budget_frames * frame_cycles + budget_presses * 2 * settle_cycles);

    // Board pin roles after key reversal
    localparam int inc_pin = reverse_keys ? 1 : 0;
    localparam int clr_pin = reverse_keys ? 0 : 1;

    logic             clk;
    logic             i_reset;
    logic [w_key-1:0] i_key;
    logic             o_tm_stb;
    logic             o_tm_clk;
    logic             o_tm_dio;

    int          error_count;
    logic [15:0] lfsr_state;
    logic [31:0] model_value;          // Counter value the board should show
    logic [15:0] rx_shift;
    int          rx_bits;
    logic        rx_open;
    logic [7:0]  rx_addr [$];
    logic [7:0]  rx_data [$];

    logic [7:0] seg_table [16] = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
                                   8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71};

    board_top dut0 (
        .clk      ( clk      ),
        .i_reset  ( i_reset  ),
        .i_key    ( i_key    ),
        .o_tm_stb ( o_tm_stb ),
        .o_tm_clk ( o_tm_clk ),
        .o_tm_dio ( o_tm_dio )
    );

    always #(clk_period / 2) clk = ~clk;

    //--------------------------------------------------
    // Serial monitor
    //--------------------------------------------------

    always @(negedge o_tm_stb) begin
        rx_open = 1'b1;
        rx_bits = 0;
    end

    always @(posedge o_tm_clk) begin
        if (o_tm_stb === 1'b0) begin
            rx_shift = {o_tm_dio, rx_shift[15:1]};  // LSB arrives first
            rx_bits++;
        end
    end

    always @(posedge o_tm_stb) begin
        if (rx_open) begin
            rx_open = 1'b0;
            if (rx_bits != 16) begin
                error_count++;
                $display("Serial window at time %0t held %0d bits instead of 16", $time, rx_bits);
            end else begin
                rx_addr.push_back(rx_shift[7:0]);
                rx_data.push_back(rx_shift[15:8]);
            end
        end
    end

    //--------------------------------------------------
    // Helpers
    //--------------------------------------------------

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("Error at time %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic random_bits(input int nbits, output int value);
        value = 0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | lfsr_state[0];
        end
    endtask

    task automatic press_pin(input int pin);
        @(posedge clk);
        i_key[pin] <= 1'b0;
        repeat (settle_cycles) @(posedge clk);
        i_key[pin] <= 1'b1;
        repeat (settle_cycles) @(posedge clk);
        model_value = (pin == clr_pin) ? '0 : model_value + 1;
    endtask

    task automatic wait_words(input int n, output bit ok);
        int waited;
        waited = 0;
        while (rx_addr.size() < n && waited < 3 * frame_cycles) begin
            @(negedge clk);
            waited++;
        end
        ok = (rx_addr.size() >= n);
        if (!ok) begin
            error_count++;
            $display("No complete frame arrived within %0d cycles, time %0t", waited, $time);
        end
    endtask

    // Value comes back from the LED words, then all 16 words are checked against it
    task automatic receive_frame(output logic [31:0] value, output bit ok);
        logic [7:0] exp_addr;
        logic [7:0] exp_data;
        wait_words(16, ok);
        value = '0;
        if (ok) begin
            for (int i = 0; i < 8; i++) begin
                value[i] = rx_data[8 + i][0];
            end
            for (int p = 0; p < 16; p++) begin
                if (p < w_tm_digit) begin
                    exp_addr = 8'hC0 + 8'(2 * p);
                    exp_data = seg_table[value[4 * (7 - p) +: 4]];  // Digit 0 is top nibble
                end else begin
                    exp_addr = 8'hC1 + 8'(2 * (p - 8));
                    exp_data = {7'b0, value[p - 8]};
                end
                compare_value($sformatf("word %0d address", p), rx_addr.pop_front(), exp_addr);
                compare_value($sformatf("word %0d data", p), rx_data.pop_front(), exp_data);
            end
        end
    endtask

    task automatic drain_until(input logic [31:0] target);
        logic [31:0] value;
        logic [31:0] prev;
        bit          ok;
        prev = '0;
        do begin
            receive_frame(value, ok);
            if (ok) begin
                compare_value("frame value not decreasing", value >= prev, 1);
            end
            prev = value;
        end while (ok && value != target);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(negedge clk);
        compare_value("words outside a frame", rx_addr.size(), 0);
    endtask

    //--------------------------------------------------
    // Directed tests
    //--------------------------------------------------

    task automatic test_reset_frame();
        logic [31:0] value;
        bit          ok;
        compare_value("o_tm_stb", o_tm_stb, 1);
        compare_value("o_tm_clk", o_tm_clk, 1);
        receive_frame(value, ok);
        compare_value("first frame value", value, 0);
        expect_quiet(frame_cycles);                // Only one frame after reset
    endtask

    task automatic test_increment();
        logic [31:0] value;
        bit          ok;
        @(posedge clk);
        i_key[inc_pin] <= 1'b0;
        model_value = model_value + 1;
        receive_frame(value, ok);
        compare_value("frame value after increment", value, model_value);
        expect_quiet(frame_cycles);                // Still held
        @(posedge clk);
        i_key[inc_pin] <= 1'b1;
        expect_quiet(settle_cycles);
    endtask

    task automatic test_bounce();
        int glitch;
        int gap;
        for (int g = 0; g < 6; g++) begin
            random_bits(3, glitch);
            random_bits(3, gap);
            @(posedge clk);
            i_key[inc_pin] <= 1'b0;
            repeat (glitch + 4) @(posedge clk);    // 4 to 11 cycles, under debounce_cycles
            i_key[inc_pin] <= 1'b1;
            repeat (gap + 2) @(posedge clk);
        end
        expect_quiet(frame_cycles);
    endtask

    task automatic test_clear();
        for (int i = 0; i < 3; i++) begin
            press_pin(inc_pin);
        end
        drain_until(model_value);
        press_pin(clr_pin);
        drain_until(0);
        expect_quiet(frame_cycles);
    endtask

    task automatic test_burst();
        int n;
        random_bits(3, n);
        n = n + 3;                                 // 3 to 10 presses
        for (int i = 0; i < n; i++) begin
            press_pin(inc_pin);
        end
        drain_until(n);
        expect_quiet(frame_cycles);
    endtask

    task automatic test_key_reversal();
        press_pin(1);
        drain_until(model_value);
        press_pin(0);
        drain_until(model_value);
    endtask

    //--------------------------------------------------
    // Main sequence and watchdog
    //--------------------------------------------------

    initial begin
        clk         = 1'b0;
        i_reset     = 1'b1;
        i_key       = '1;                          // Buttons released
        error_count = 0;
        lfsr_state  = 16'd4;
        model_value = '0;
        rx_shift    = '0;
        rx_bits     = 0;
        rx_open     = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        compare_value("o_tm_stb in reset", o_tm_stb, 1);
        compare_value("o_tm_clk in reset", o_tm_clk, 1);
        @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        test_reset_frame();
        test_increment();
        test_bounce();
        test_clear();
        test_burst();
        test_key_reversal();
        $display("Tests finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(longint'(watchdog_cycles) * clk_period);
        $display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule
